// ==== design/rd_reorder_params.svh ====
//**************************************************************************
// RB_DEPTH must stay equal to 2**RB_TAG_W since every tag value owns an entry
//**************************************************************************
`ifndef RD_REORDER_PARAMS_SVH
`define RD_REORDER_PARAMS_SVH

// width of the buffer tag that the controller echoes with each return
`define RB_TAG_W 5

// number of buffer entries, one per tag value
`define RB_DEPTH 32

// width of one returned read word, a single beat per request
`define RB_DATA_W 64

`endif

// ==== design/rd_reorder_pkg.sv ====
//**************************************************************************
// types for the read reorder buffer, sized from the params header
//**************************************************************************
`include "rd_reorder_params.svh"

package rd_reorder_pkg;

  // buffer tag, which is also the index of the entry it labels
  typedef logic [`RB_TAG_W-1:0] tag_t;

  // drain pointer, the tag bits with one phase bit above them
  // the phase bit flips on every wrap of the index
  typedef logic [`RB_TAG_W:0] ptr_t;

  // one read data word
  typedef logic [`RB_DATA_W-1:0] data_t;

  // occupancy count, one bit wider than a tag so a full buffer fits
  typedef logic [`RB_TAG_W:0] occ_t;

endpackage

// ==== design/rd_tag_alloc.sv ====
//**************************************************************************
// the request source must not pulse rd_accepted while rd_buf_full is high
//**************************************************************************
`include "rd_reorder_params.svh"

module rd_tag_alloc (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_accepted,
  input  logic                  retire,
  output rd_reorder_pkg::tag_t  rd_data_buf_addr,
  output logic                  rd_buf_full
);

  import rd_reorder_pkg::*;

  // number of entries that hold an issued but not yet delivered request
  occ_t occ_cnt;

  //************************************************************************
  // tag counter
  //************************************************************************

  // each accepted read takes the current tag, so the next one is
  // offered from the following cycle on
  // the counter wraps at the buffer depth by its own width
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data_buf_addr <= '0;
    end else if (rd_accepted) begin
      rd_data_buf_addr <= rd_data_buf_addr + tag_t'(1);
    end
  end

  //************************************************************************
  // occupancy counter
  //************************************************************************

  // rises on an accepted request and falls on a delivered word
  // when both land in the same cycle the count holds
  always_ff @(posedge clk) begin
    if (rst) begin
      occ_cnt <= '0;
    end else begin
      case ({rd_accepted, retire})
        2'b10:   occ_cnt <= occ_cnt + occ_t'(1);
        2'b01:   occ_cnt <= occ_cnt - occ_t'(1);
        default: occ_cnt <= occ_cnt;
      endcase
    end
  end

  // look ahead by one request so the source sees the flag in the same
  // cycle it takes the last free entry
  assign rd_buf_full = (occ_cnt == occ_t'(`RB_DEPTH)) ||
                       ((occ_cnt == occ_t'(`RB_DEPTH - 1)) && rd_accepted);

  // every delivered word belongs to an earlier accepted request
  a_no_retire_when_empty : assert property (@(posedge clk) disable iff (rst)
    retire |-> (occ_cnt != occ_t'(0)))
    else $error("retire seen with no outstanding request");

  // the source has to honour the full flag it saw in the previous cycles
  a_no_accept_when_full : assert property (@(posedge clk) disable iff (rst)
    rd_accepted |-> (occ_cnt != occ_t'(`RB_DEPTH)))
    else $error("read accepted while all entries are occupied");

endmodule

// ==== design/rd_return_store.sv ====
//**************************************************************************
// each issued tag must return exactly once, returns have no back-pressure
//**************************************************************************
`include "rd_reorder_params.svh"

module rd_return_store (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_data_en,
  input  rd_reorder_pkg::tag_t   rd_data_addr,
  input  rd_reorder_pkg::data_t  rd_data,
  input  rd_reorder_pkg::tag_t   drain_idx,
  output logic                   entry_sts,
  output rd_reorder_pkg::data_t  entry_data
);

  import rd_reorder_pkg::*;

  // data words, indexed by the tag echoed with the return
  data_t data_mem [`RB_DEPTH];

  // one status bit per entry, flipped by every return to that entry
  logic [`RB_DEPTH-1:0] sts_r;

  //************************************************************************
  // write side, driven by the controller returns
  //************************************************************************

  // the word lands under its tag whatever the drain is doing
  // a bypassed word is written too, the drain simply never reads it back
  always_ff @(posedge clk) begin
    if (rd_data_en) begin
      data_mem[rd_data_addr] <= rd_data;
    end
  end

  // flipping instead of setting lets the drain tell a fresh return from
  // a stale one left over from the previous lap of the index
  always_ff @(posedge clk) begin
    if (rst) begin
      sts_r <= '0;
    end else if (rd_data_en) begin
      sts_r[rd_data_addr] <= ~sts_r[rd_data_addr];
    end
  end

  //************************************************************************
  // read side, looked up at the drain index
  //************************************************************************

  // asynchronous read, like a distributed RAM
  // a return written in this cycle is not yet visible here
  assign entry_sts  = sts_r[drain_idx];
  assign entry_data = data_mem[drain_idx];

  // an unknown tag would flip some unrelated status bit
  a_ret_addr_known : assert property (@(posedge clk) disable iff (rst)
    rd_data_en |-> !$isunknown(rd_data_addr))
    else $error("return strobe with unknown tag");

endmodule

// ==== design/rd_inorder_drain.sv ====
//**************************************************************************
// the application takes every word in its valid cycle, there is no ready
//**************************************************************************
`include "rd_reorder_params.svh"

module rd_inorder_drain (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_data_en,
  input  rd_reorder_pkg::tag_t   rd_data_addr,
  input  rd_reorder_pkg::data_t  rd_data,
  input  logic                   entry_sts,
  input  rd_reorder_pkg::data_t  entry_data,
  output rd_reorder_pkg::tag_t   drain_idx,
  output logic                   app_rd_data_valid,
  output rd_reorder_pkg::data_t  app_rd_data
);

  import rd_reorder_pkg::*;

  // read pointer, index in the low bits and the lap phase on top
  ptr_t rd_ptr;
  logic phase;

  // head entry decisions for the current cycle
  logic head_ready;
  logic bypass;
  logic deliver;

  assign drain_idx = rd_ptr[`RB_TAG_W-1:0];
  assign phase     = rd_ptr[`RB_TAG_W];

  //************************************************************************
  // head decision
  //************************************************************************

  // the status bit starts equal to the phase and a return flips it, so a
  // mismatch means the word for this lap has already been stored
  assign head_ready = (entry_sts != phase);

  // a return for the head tag in this cycle is not in the store yet, so it
  // is caught here and sent straight to the output register
  assign bypass = rd_data_en && (rd_data_addr == drain_idx);

  assign deliver = head_ready || bypass;

  //************************************************************************
  // pointer and output registers
  //************************************************************************

  // one step per delivered word, so at most one word leaves per cycle
  // the carry out of the index bits flips the phase on each wrap
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (deliver) begin
      rd_ptr <= rd_ptr + ptr_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      app_rd_data_valid <= 1'b0;
    end else begin
      app_rd_data_valid <= deliver;
    end
  end

  // the incoming word wins on a bypass since the stored copy is stale
  always_ff @(posedge clk) begin
    if (deliver) begin
      app_rd_data <= bypass ? rd_data : entry_data;
    end
  end

  // the head tag cannot come back while its word for this lap is already
  // stored, that would be a second return of the same request
  a_single_return : assert property (@(posedge clk) disable iff (rst)
    bypass |-> !head_ready)
    else $error("head tag returned while its word was already stored");

endmodule

// ==== design/rd_reorder_top.sv ====
//**************************************************************************
// read reorder buffer, 32 tags, one returned word per request
//**************************************************************************

module rd_reorder_top (
  input  logic                   clk,
  input  logic                   rst,
  // request side
  input  logic                   rd_accepted,
  output rd_reorder_pkg::tag_t   rd_data_buf_addr,
  output logic                   rd_buf_full,
  // returns from the memory controller
  input  logic                   rd_data_en,
  input  rd_reorder_pkg::tag_t   rd_data_addr,
  input  rd_reorder_pkg::data_t  rd_data,
  // in-order data to the application
  output logic                   app_rd_data_valid,
  output rd_reorder_pkg::data_t  app_rd_data
);

  import rd_reorder_pkg::*;

  // head lookup between the drain and the store
  tag_t  drain_idx;
  logic  entry_sts;
  data_t entry_data;

  // tags out to the controller, occupancy and the full flag
  // every delivered word frees one entry
  rd_tag_alloc u_tag_alloc (
    .clk              (clk),
    .rst              (rst),
    .rd_accepted      (rd_accepted),
    .retire           (app_rd_data_valid),
    .rd_data_buf_addr (rd_data_buf_addr),
    .rd_buf_full      (rd_buf_full)
  );

  // out-of-order returns are parked here under their tag
  rd_return_store u_return_store (
    .clk          (clk),
    .rst          (rst),
    .rd_data_en   (rd_data_en),
    .rd_data_addr (rd_data_addr),
    .rd_data      (rd_data),
    .drain_idx    (drain_idx),
    .entry_sts    (entry_sts),
    .entry_data   (entry_data)
  );

  // walks the tags in request order and hands words to the application
  rd_inorder_drain u_inorder_drain (
    .clk               (clk),
    .rst               (rst),
    .rd_data_en        (rd_data_en),
    .rd_data_addr      (rd_data_addr),
    .rd_data           (rd_data),
    .entry_sts         (entry_sts),
    .entry_data        (entry_data),
    .drain_idx         (drain_idx),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data       (app_rd_data)
  );

endmodule

// ==== test/tb_rd_reorder.sv ====
//**************************************************************************
// tags are modelled in the testbench and compared with the DUT at each
// accept, the full flag is predicted from a model of the occupancy
//**************************************************************************
`include "rd_reorder_params.svh"

module tb_rd_reorder;

  import rd_reorder_pkg::*;

  localparam int TIMEOUT_CYCLES = 1000;
  localparam int SEED           = 87;
  localparam int RAND_REQS      = 60;

  logic  clk;
  logic  rst;
  logic  rd_accepted;
  logic  rd_data_en;
  tag_t  rd_data_addr;
  data_t rd_data;
  tag_t  rd_data_buf_addr;
  logic  rd_buf_full;
  logic  app_rd_data_valid;
  data_t app_rd_data;

  int   errors;
  int   timeouts;
  // high while returns come back strictly in request order
  bit   inorder;
  // next tag that the DUT should hand out
  tag_t exp_tag;
  // issued but not yet delivered, updated on the rising edge like the DUT
  int   occ_model;

  // scoreboard in request order, and the tags still waiting for a return
  tag_t  sb_tag_q[$];
  data_t sb_data_q[$];
  tag_t  pend_tag_q[$];
  data_t pend_data_q[$];
  bit    returned [`RB_DEPTH];

  rd_reorder_top UUT (
    .clk               (clk),
    .rst               (rst),
    .rd_accepted       (rd_accepted),
    .rd_data_buf_addr  (rd_data_buf_addr),
    .rd_buf_full       (rd_buf_full),
    .rd_data_en        (rd_data_en),
    .rd_data_addr      (rd_data_addr),
    .rd_data           (rd_data),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data       (app_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //************************************************************************
  // output monitor and scoreboard
  //************************************************************************

  // the head of the scoreboard must have returned before its word shows up
  always @(posedge clk) begin : monitor
    tag_t  head_tag;
    data_t head_data;
    if (!rst) begin
      occ_model = occ_model + (rd_accepted ? 1 : 0) - (app_rd_data_valid ? 1 : 0);
      if (app_rd_data_valid) begin
        if (sb_tag_q.size() == 0) begin
          errors++;
          $display("FAILED at %0t: word delivered with no request outstanding", $time);
        end else begin
          head_tag  = sb_tag_q.pop_front();
          head_data = sb_data_q.pop_front();
          assert (returned[head_tag]) else begin
            errors++;
            $display("FAILED at %0t: tag %0d delivered before its return", $time, head_tag);
          end
          assert (app_rd_data == head_data) else begin
            errors++;
            $display("FAILED at %0t: tag %0d gave %h, expected %h",
                     $time, head_tag, app_rd_data, head_data);
          end
          returned[head_tag] = 1'b0;
        end
      end
    end
  end

  // full at 32 entries, or at 31 while one more request is taken
  a_full_flag : assert property (@(posedge clk) disable iff (rst)
    rd_buf_full == ((occ_model == `RB_DEPTH) ||
                    ((occ_model == `RB_DEPTH - 1) && rd_accepted)))
    else begin
      errors++;
      $display("FAILED at %0t: rd_buf_full %0b at occupancy %0d",
               $time, rd_buf_full, occ_model);
    end

  a_tag_step : assert property (@(posedge clk) disable iff (rst)
    rd_accepted |=> (rd_data_buf_addr == $past(rd_data_buf_addr) + tag_t'(1)))
    else begin
      errors++;
      $display("FAILED at %0t: tag did not step after an accept", $time);
    end

  // with in-order returns every return hits the head and bypasses
  a_bypass_timing : assert property (@(posedge clk) disable iff (rst)
    (inorder && rd_data_en) |=> (app_rd_data_valid && (app_rd_data == $past(rd_data))))
    else begin
      errors++;
      $display("FAILED at %0t: bypassed word missing one cycle after its return", $time);
    end

  a_no_early_word : assert property (@(posedge clk) disable iff (rst)
    (inorder && !rd_data_en) |=> !app_rd_data_valid)
    else begin
      errors++;
      $display("FAILED at %0t: word delivered without a return in order", $time);
    end

  //************************************************************************
  // run control
  //************************************************************************

  task automatic end_run();
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
  endtask

  // one cycle of stimulus, an accept only goes out while the flag shows room
  task automatic drive_cycle(input bit want_acc, input bit want_ret,
                             input bit oldest_first, output bit took);
    int    idx;
    data_t word;
    @(negedge clk);
    took       = want_acc && !rd_buf_full;
    rd_data_en = 1'b0;
    if (want_ret && pend_tag_q.size() > 0) begin
      idx = oldest_first ? 0 : int'($urandom % pend_tag_q.size());
      rd_data_en   = 1'b1;
      rd_data_addr = pend_tag_q[idx];
      rd_data      = pend_data_q[idx];
      returned[pend_tag_q[idx]] = 1'b1;
      pend_tag_q.delete(idx);
      pend_data_q.delete(idx);
    end
    rd_accepted = took;
    if (took) begin
      word = {$urandom, $urandom};
      assert (rd_data_buf_addr == exp_tag) else begin
        errors++;
        $display("FAILED at %0t: tag %0d offered, expected %0d",
                 $time, rd_data_buf_addr, exp_tag);
      end
      sb_tag_q.push_back(exp_tag);
      sb_data_q.push_back(word);
      pend_tag_q.push_back(exp_tag);
      pend_data_q.push_back(word);
      exp_tag = exp_tag + tag_t'(1);
    end
  endtask

  // requests with an idle cycle between them, so the flag is read unloaded
  task automatic issue_spaced(input int n);
    int done_cnt;
    int cycles;
    bit took;
    done_cnt = 0;
    cycles   = 0;
    while (done_cnt < n && cycles < TIMEOUT_CYCLES) begin
      drive_cycle(1'b1, 1'b0, 1'b0, took);
      if (took) begin
        done_cnt++;
      end
      drive_cycle(1'b0, 1'b0, 1'b0, took);
      cycles++;
    end
    if (done_cnt < n) begin
      report_timeout("free buffer entries");
    end
  endtask

  task automatic return_all(input bit oldest_first);
    int cycles;
    bit took;
    cycles = 0;
    while (pend_tag_q.size() > 0 && cycles < TIMEOUT_CYCLES) begin
      drive_cycle(1'b0, 1'b1, oldest_first, took);
      cycles++;
    end
    if (pend_tag_q.size() > 0) begin
      report_timeout("all returns to be sent");
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (sb_tag_q.size() > 0 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      rd_accepted = 1'b0;
      rd_data_en  = 1'b0;
      cycles++;
    end
    if (sb_tag_q.size() > 0) begin
      report_timeout("the scoreboard to drain");
    end
  endtask

  //************************************************************************
  // stimulus
  //************************************************************************

  initial begin
    bit took;
    int issued;
    int cycles;
    void'($urandom(SEED));
    rst          = 1'b1;
    rd_accepted  = 1'b0;
    rd_data_en   = 1'b0;
    rd_data_addr = '0;
    rd_data      = '0;
    errors       = 0;
    timeouts     = 0;
    inorder      = 1'b0;
    exp_tag      = '0;
    occ_model    = 0;
    foreach (returned[i]) begin
      returned[i] = 1'b0;
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;
    assert (!app_rd_data_valid && !rd_buf_full && rd_data_buf_addr == tag_t'(0)) else begin
      errors++;
      $display("FAILED at %0t: outputs not cleared by reset", $time);
    end

    // two batches returned in order, the tag counter wraps at the end
    inorder = 1'b1;
    repeat (2) begin
      issue_spaced(16);
      return_all(1'b1);
    end
    wait_drained();
    inorder = 1'b0;

    // accepts and shuffled returns mixed at random
    issued = 0;
    cycles = 0;
    while ((issued < RAND_REQS || pend_tag_q.size() > 0) && cycles < TIMEOUT_CYCLES) begin
      drive_cycle(issued < RAND_REQS && $urandom_range(3) != 0,
                  $urandom_range(1) == 1, 1'b0, took);
      if (took) begin
        issued++;
      end
      cycles++;
    end
    if (issued < RAND_REQS || pend_tag_q.size() > 0) begin
      report_timeout("the random traffic to finish");
    end
    wait_drained();

    // fill every entry, then free the oldest one
    issue_spaced(`RB_DEPTH);
    @(negedge clk);
    assert (rd_buf_full) else begin
      errors++;
      $display("FAILED at %0t: rd_buf_full low with every entry taken", $time);
    end
    drive_cycle(1'b0, 1'b1, 1'b1, took);
    cycles = 0;
    while (rd_buf_full && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      rd_data_en = 1'b0;
      cycles++;
    end
    if (rd_buf_full) begin
      report_timeout("rd_buf_full to fall");
    end
    assert (sb_tag_q.size() == `RB_DEPTH - 1) else begin
      errors++;
      $display("FAILED at %0t: %0d words still queued after the first delivery",
               $time, sb_tag_q.size());
    end
    return_all(1'b0);
    wait_drained();

    @(negedge clk);
    assert (!rd_buf_full && occ_model == 0) else begin
      errors++;
      $display("FAILED at %0t: occupancy %0d left after the drain", $time, occ_model);
    end
    end_run();
  end

endmodule

// ==== flist.f ====
+incdir+design
design/rd_reorder_pkg.sv
design/rd_tag_alloc.sv
design/rd_return_store.sv
design/rd_inorder_drain.sv
design/rd_reorder_top.sv
test/tb_rd_reorder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the read reorder buffer testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f flist.f \
  --top-module tb_rd_reorder \
  -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
run_status=$?
echo "$output"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
else
  echo "pass line not found in the simulation output"
  exit 1
fi
